// File: logic/pi1_pkg.sv
`default_nettype none

// pi1 bus definitions shared by the cores, the arbiter and the top level
package pi1_pkg;

	// data width of one bus word
	localparam int ARCHBITSZ = 16;

	// one select bit per byte of the word
	localparam int SELBITSZ = ARCHBITSZ / 8;

	// word address, byte offset bits dropped
	localparam int ADDRBITSZ = ARCHBITSZ - $clog2(SELBITSZ);

	// bus operation, encoded as on PerInt
	// PI1_RW swaps a word in one access
	// kept for bus compatibility, the cores never issue it
	typedef enum logic [1:0] {
		PI1_NOP = 2'b00,
		PI1_WR  = 2'b01,
		PI1_RD  = 2'b10,
		PI1_RW  = 2'b11
	} pi1_op_t;

endpackage

`default_nettype wire

// File: logic/pu_pkg.sv
`default_nettype none

// instruction set of the accumulator core
package pu_pkg;

	// instruction word layout
	// opcode in the top bits, operand below it
	localparam int OPCBITSZ  = 4;
	localparam int OPNDBITSZ = 12;
	localparam int INSNBITSZ = OPCBITSZ + OPNDBITSZ;

	// opcodes
	// memory operands are word addresses, zero-extended
	// codes not listed here behave as no-operation
	typedef enum logic [OPCBITSZ-1:0] {
		// acc = operand, zero-extended
		OP_LDI   = 4'h1,
		// acc = mem[operand]
		OP_LD    = 4'h2,
		// mem[operand] = acc
		OP_ST    = 4'h3,
		// acc = acc +/- mem[operand], wraps at 16 bits
		OP_ADD   = 4'h4,
		OP_SUB   = 4'h5,
		// acc = unit id, or acc plus unit id
		OP_ID    = 4'h6,
		OP_ADDID = 4'h7,
		// jumps, the conditional one tests acc against zero
		OP_JMP   = 4'h8,
		OP_JNZ   = 4'h9,
		// stop until the next reset
		OP_HALT  = 4'hf
	} pu_opcode_t;

	// core sequencer states
	typedef enum logic [1:0] {
		PU_FETCH  = 2'd0,
		PU_DECODE = 2'd1,
		PU_MEM    = 2'd2,
		PU_HALTED = 2'd3
	} pu_state_t;

endpackage

`default_nettype wire

// File: logic/pi1_arbiter.sv
`default_nettype none
`timescale 1ns/1ps

// round-robin arbiter merging PUCOUNT pi1 masters onto one slave port
// requests pass through in the same cycle, only the grant is registered
module pi1_arbiter
	import pi1_pkg::*;
#(
	parameter int PUCOUNT = 2
) (
	input  wire                                  clk_i,
	input  wire                                  reset_i,

	// master side, one entry per unit
	input  pi1_op_t [PUCOUNT-1:0]                m_op_i,
	input  wire     [PUCOUNT-1:0][ADDRBITSZ-1:0] m_addr_i,
	input  wire     [PUCOUNT-1:0][ARCHBITSZ-1:0] m_data_i,
	output logic    [PUCOUNT-1:0][ARCHBITSZ-1:0] m_data_o,
	input  wire     [PUCOUNT-1:0][SELBITSZ-1:0]  m_sel_i,
	output logic    [PUCOUNT-1:0]                m_rdy_o,

	// slave side
	output pi1_op_t                              s_op_o,
	output logic    [ADDRBITSZ-1:0]              s_addr_o,
	output logic    [ARCHBITSZ-1:0]              s_data_o,
	input  wire     [ARCHBITSZ-1:0]              s_data_i,
	output logic    [SELBITSZ-1:0]               s_sel_o,
	input  wire                                  s_rdy_i
);

	// a single master still needs a one bit grant
	localparam int GNTBITSZ = (PUCOUNT > 1) ? $clog2(PUCOUNT) : 1;

	logic [GNTBITSZ-1:0] gnt_q;
	logic [GNTBITSZ-1:0] gnt_nxt_w;
	logic                gnt_move_w;

	// granted request straight onto the slave port
	assign s_op_o   = m_op_i[gnt_q];
	assign s_addr_o = m_addr_i[gnt_q];
	assign s_data_o = m_data_i[gnt_q];
	assign s_sel_o  = m_sel_i[gnt_q];

	// rdy and read data go back to the granted master only
	// everyone else keeps waiting with rdy low
	always_comb begin
		for (int i = 0; i < PUCOUNT; i++) begin
			m_rdy_o[i]  = s_rdy_i && (gnt_q == GNTBITSZ'(i));
			m_data_o[i] = (gnt_q == GNTBITSZ'(i)) ? s_data_i : '0;
		end
	end

	// grant may only leave an idle master or one finishing its access
	// so a pending request is never cut off mid-transfer
	assign gnt_move_w = (m_op_i[gnt_q] == PI1_NOP) || s_rdy_i;

	// next requester, searching from the one after the current grant
	// the last step wraps to the current master itself
	always_comb begin
		int  idx;
		logic found;
		gnt_nxt_w = gnt_q;
		found     = 1'b0;
		for (int k = 1; k <= PUCOUNT; k++) begin
			idx = int'(gnt_q) + k;
			if (idx >= PUCOUNT) begin
				idx = idx - PUCOUNT;
			end
			if (!found && (m_op_i[idx] != PI1_NOP)) begin
				gnt_nxt_w = GNTBITSZ'(idx);
				found     = 1'b1;
			end
		end
	end

	// grant register, unit 0 first after reset
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			gnt_q <= '0;
		end else if (gnt_move_w) begin
			gnt_q <= gnt_nxt_w;
		end
	end

endmodule

`default_nettype wire

// File: logic/pu.sv
`default_nettype none
`timescale 1ns/1ps

// 16-bit accumulator core, pi1 bus master
// one bus access at a time: fetch, decode, then an optional data access
module pu
	import pi1_pkg::*;
	import pu_pkg::*;
(
	input  wire                  clk_i,
	input  wire                  reset_i,

	// pi1 master port
	output pi1_op_t              pi1_op_o,
	output logic [ADDRBITSZ-1:0] pi1_addr_o,
	output logic [ARCHBITSZ-1:0] pi1_data_o,
	input  wire  [ARCHBITSZ-1:0] pi1_data_i,
	output logic [SELBITSZ-1:0]  pi1_sel_o,
	input  wire                  pi1_rdy_i,

	// execution start address, sampled while in reset
	input  wire  [ADDRBITSZ-1:0] rstaddr_i,
	// unit id, visible to software through OP_ID and OP_ADDID
	input  wire  [ARCHBITSZ-1:0] id_i,

	output logic                 halted_o
);

	pu_state_t state_q;

	// program counter, word address
	logic [ADDRBITSZ-1:0] pc_q;
	logic [ARCHBITSZ-1:0] acc_q;

	// instruction register, loaded by the fetch
	logic [INSNBITSZ-1:0] ir_q;

	// low for one cycle after reset so the bus starts idle
	logic run_q;

	// instruction fields
	pu_opcode_t           opc_w;
	logic [OPNDBITSZ-1:0] opnd_w;
	logic [ADDRBITSZ-1:0] opnd_addr_w;
	logic [ARCHBITSZ-1:0] imm_w;

	// current access completes this cycle
	logic done_w;

	assign opc_w  = pu_opcode_t'(ir_q[INSNBITSZ-1 -: OPCBITSZ]);
	assign opnd_w = ir_q[OPNDBITSZ-1:0];

	// operand as data address and as immediate, both zero-extended
	assign opnd_addr_w = {{(ADDRBITSZ-OPNDBITSZ){1'b0}}, opnd_w};
	assign imm_w       = {{(ARCHBITSZ-OPNDBITSZ){1'b0}}, opnd_w};

	// rdy only counts while a request is on the bus
	assign done_w = (pi1_op_o != PI1_NOP) && pi1_rdy_i;

	// bus request follows the state
	// address is pc unless a data access is pending
	always_comb begin
		pi1_op_o   = PI1_NOP;
		pi1_addr_o = pc_q;
		case (state_q)
			PU_FETCH: begin
				if (run_q) begin
					pi1_op_o = PI1_RD;
				end
			end
			PU_MEM: begin
				pi1_addr_o = opnd_addr_w;
				pi1_op_o   = (opc_w == OP_ST) ? PI1_WR : PI1_RD;
			end
			default: begin
				pi1_op_o = PI1_NOP;
			end
		endcase
	end

	// store data is always the accumulator
	assign pi1_data_o = acc_q;

	// whole words only
	assign pi1_sel_o = '1;

	assign halted_o = (state_q == PU_HALTED);

	// instruction word capture on fetch completion
	always_ff @(posedge clk_i) begin
		if ((state_q == PU_FETCH) && done_w) begin
			ir_q <= pi1_data_i;
		end
	end

	// sequencer
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state_q <= PU_FETCH;
			pc_q    <= rstaddr_i;
			acc_q   <= '0;
			run_q   <= 1'b0;
		end else begin
			run_q <= 1'b1;
			case (state_q)
				PU_FETCH: begin
					// wait for the instruction word, then step past it
					if (done_w) begin
						pc_q    <= pc_q + 1'b1;
						state_q <= PU_DECODE;
					end
				end
				PU_DECODE: begin
					state_q <= PU_FETCH;
					case (opc_w)
						OP_LDI: begin
							acc_q <= imm_w;
						end
						OP_LD, OP_ADD, OP_SUB, OP_ST: begin
							// needs a data access first
							state_q <= PU_MEM;
						end
						OP_ID: begin
							acc_q <= id_i;
						end
						OP_ADDID: begin
							acc_q <= acc_q + id_i;
						end
						OP_JMP: begin
							pc_q <= opnd_addr_w;
						end
						OP_JNZ: begin
							if (acc_q != '0) begin
								pc_q <= opnd_addr_w;
							end
						end
						OP_HALT: begin
							state_q <= PU_HALTED;
						end
						default: begin
							// unknown code, nothing to do
							state_q <= PU_FETCH;
						end
					endcase
				end
				PU_MEM: begin
					// read data is valid in the rdy cycle
					if (done_w) begin
						case (opc_w)
							OP_LD: begin
								acc_q <= pi1_data_i;
							end
							OP_ADD: begin
								acc_q <= acc_q + pi1_data_i;
							end
							OP_SUB: begin
								acc_q <= acc_q - pi1_data_i;
							end
							default: begin
								// store, memory already updated
								acc_q <= acc_q;
							end
						endcase
						state_q <= PU_FETCH;
					end
				end
				PU_HALTED: begin
					// parked until reset
					state_q <= PU_HALTED;
				end
				default: begin
					state_q <= PU_FETCH;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: logic/multipu.sv
`default_nettype none
`timescale 1ns/1ps

// cluster of PUCOUNT accumulator cores sharing one pi1 slave port
// unit 0 boots at rstaddr_i, the others at rstaddr2_i
// each unit sees id_i plus its index as its id
module multipu
	import pi1_pkg::*;
#(
	// 1 to 4 units
	parameter int PUCOUNT = 2
) (
	input  wire                  clk_i,
	input  wire                  reset_i,

	// pi1 port towards memory
	output pi1_op_t              pi1_op_o,
	output logic [ADDRBITSZ-1:0] pi1_addr_o,
	output logic [ARCHBITSZ-1:0] pi1_data_o,
	input  wire  [ARCHBITSZ-1:0] pi1_data_i,
	output logic [SELBITSZ-1:0]  pi1_sel_o,
	input  wire                  pi1_rdy_i,

	// start addresses
	input  wire  [ADDRBITSZ-1:0] rstaddr_i,
	input  wire  [ADDRBITSZ-1:0] rstaddr2_i,

	// id of unit 0
	input  wire  [ARCHBITSZ-1:0] id_i,

	// one bit per unit
	output logic [PUCOUNT-1:0]   halted_o
);

	// per-unit bus between the cores and the arbiter
	pi1_op_t [PUCOUNT-1:0]                m_op_w;
	logic    [PUCOUNT-1:0][ADDRBITSZ-1:0] m_addr_w;
	logic    [PUCOUNT-1:0][ARCHBITSZ-1:0] m_wdata_w;
	logic    [PUCOUNT-1:0][ARCHBITSZ-1:0] m_rdata_w;
	logic    [PUCOUNT-1:0][SELBITSZ-1:0]  m_sel_w;
	logic    [PUCOUNT-1:0]                m_rdy_w;

	pi1_arbiter #(
		.PUCOUNT (PUCOUNT)
	) arbiter_i (
		.clk_i    (clk_i),
		.reset_i  (reset_i),
		.m_op_i   (m_op_w),
		.m_addr_i (m_addr_w),
		.m_data_i (m_wdata_w),
		.m_data_o (m_rdata_w),
		.m_sel_i  (m_sel_w),
		.m_rdy_o  (m_rdy_w),
		.s_op_o   (pi1_op_o),
		.s_addr_o (pi1_addr_o),
		.s_data_o (pi1_data_o),
		.s_data_i (pi1_data_i),
		.s_sel_o  (pi1_sel_o),
		.s_rdy_i  (pi1_rdy_i)
	);

	for (genvar gen_idx = 0; gen_idx < PUCOUNT; gen_idx++) begin : genpu
		pu pu_i (
			.clk_i      (clk_i),
			.reset_i    (reset_i),
			.pi1_op_o   (m_op_w[gen_idx]),
			.pi1_addr_o (m_addr_w[gen_idx]),
			.pi1_data_o (m_wdata_w[gen_idx]),
			.pi1_data_i (m_rdata_w[gen_idx]),
			.pi1_sel_o  (m_sel_w[gen_idx]),
			.pi1_rdy_i  (m_rdy_w[gen_idx]),
			// only unit 0 uses the primary start address
			.rstaddr_i  ((gen_idx == 0) ? rstaddr_i : rstaddr2_i),
			.id_i       (id_i + ARCHBITSZ'(gen_idx)),
			.halted_o   (halted_o[gen_idx])
		);
	end

endmodule

`default_nettype wire

// File: verification/clock_gen.sv
`default_nettype none
`timescale 1ns/1ps

// testbench clock and synchronous reset
// reset is high for RESET_CYCLES edges at start and again after each request
module clock_gen #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 3
) (
	input  wire  reset_req_i,
	output logic clk_o   = 1'b0,
	output logic reset_o = 1'b1
);

	int unsigned cycles_left = RESET_CYCLES;

	always #(PERIOD_NS / 2) clk_o = ~clk_o;

	always @(posedge clk_o) begin
		if (reset_req_i) begin
			reset_o     <= 1'b1;
			cycles_left = RESET_CYCLES;
		end else if (cycles_left > 0) begin
			cycles_left = cycles_left - 1;
			// release after the last counted edge
			if (cycles_left == 0) begin
				reset_o <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: verification/multipu_assertions.sv
`default_nettype none
`timescale 1ns/1ps

// pi1 slave port and halted_o checks, bound into multipu
module multipu_assertions
	import pi1_pkg::*;
#(
	parameter int PUCOUNT = 2
) (
	input  wire                  clk_i,
	input  wire                  reset_i,
	input  pi1_op_t              pi1_op_i,
	input  wire  [ADDRBITSZ-1:0] pi1_addr_i,
	input  wire  [ARCHBITSZ-1:0] pi1_wdata_i,
	input  wire                  pi1_rdy_i,
	input  wire  [PUCOUNT-1:0]   halted_i
);

	// one flag per property, the testbench reads any_fail
	logic stable_fail = 1'b0;
	logic reset_fail  = 1'b0;
	logic halt_fail   = 1'b0;
	logic any_fail;

	assign any_fail = stable_fail | reset_fail | halt_fail;

	// a pending request holds op, address and data until rdy
	assert property (@(posedge clk_i) disable iff (reset_i)
		(pi1_op_i != PI1_NOP) && !pi1_rdy_i |=>
			$stable(pi1_op_i) && $stable(pi1_addr_i) && $stable(pi1_wdata_i))
	else begin
		$error("pi1 request changed while waiting for rdy");
		stable_fail = 1'b1;
	end

	// bus idle in the first cycle out of reset
	assert property (@(posedge clk_i) $fell(reset_i) |-> (pi1_op_i == PI1_NOP))
	else begin
		$error("pi1 op not idle in the first cycle after reset");
		reset_fail = 1'b1;
	end

	// any halted bit stays set until the next reset
	assert property (@(posedge clk_i) disable iff (reset_i)
		(halted_i != '0) |=> ((halted_i & $past(halted_i)) == $past(halted_i)))
	else begin
		$error("a halted_o bit dropped without reset");
		halt_fail = 1'b1;
	end

endmodule

`default_nettype wire

// File: verification/multipu_tb.sv
`default_nettype none
`timescale 1ns/1ps

// two-unit cluster against a pi1 memory model with random rdy delay
module multipu_tb
	import pi1_pkg::*;
	import pu_pkg::*;
();

	localparam int PUCOUNT  = 2;
	localparam int MEMWORDS = 4096;
	localparam int NSCEN    = 3;
	// 3 runs, under 200 instructions per unit, 2 accesses each,
	// up to 5 cycles per access with the other unit queued ahead
	localparam int TIMEOUT_CYCLES = 20000;
	localparam logic [ARCHBITSZ-1:0] SCEN_ID [NSCEN] = '{16'h0004, 16'h0031, 16'h0017};

	// memory map
	localparam logic [ADDRBITSZ-1:0] START0 = 15'h010;
	localparam logic [ADDRBITSZ-1:0] START1 = 15'h080;
	localparam int TABLE_BASE = 'h200;
	localparam int TABLE_LEN  = 5;
	localparam int SUM_A  = 'h300;
	localparam int CNT_A  = 'h301;
	localparam int ZERO_A = 'h302;
	localparam int N_A    = 'h303;
	localparam int ONE_A  = 'h304;
	localparam int RES_A  = 'h305;
	// holds the OP_ST opcode for patching store instructions
	localparam int STOP_A = 'h0a0;
	localparam int OUT0_A = 'h400;
	localparam int OUT1_A = 'h410;

	typedef logic [ARCHBITSZ-1:0] image_t [0:MEMWORDS-1];

	logic                 clk_i;
	logic                 reset_i;
	logic                 reset_req = 1'b0;
	pi1_op_t              pi1_op_o;
	logic [ADDRBITSZ-1:0] pi1_addr_o;
	logic [ARCHBITSZ-1:0] pi1_data_o;
	logic [ARCHBITSZ-1:0] pi1_data_i = '0;
	logic [SELBITSZ-1:0]  pi1_sel_o;
	logic                 pi1_rdy_i  = 1'b0;
	logic [ADDRBITSZ-1:0] rstaddr_i  = START0;
	logic [ADDRBITSZ-1:0] rstaddr2_i = START1;
	logic [ARCHBITSZ-1:0] id_i       = '0;
	logic [PUCOUNT-1:0]   halted_o;

	// image is loaded into mem during reset, mem is what the DUT sees
	image_t      mem;
	image_t      image;
	image_t      expected;
	logic [1:0]  delay_tab [0:MEMWORDS-1];
	logic [11:0] delay_idx  = '0;
	logic [1:0]  wait_cnt   = '0;
	logic        armed      = 1'b0;
	logic        first_seen = 1'b0;
	int          wr_ptr;
	int          cycle_cnt  = 0;
	int          check_req  = 0;
	int          check_done = 0;

	clock_gen clock_gen_i (
		.reset_req_i (reset_req),
		.clk_o       (clk_i),
		.reset_o     (reset_i)
	);

	multipu #(
		.PUCOUNT (PUCOUNT)
	) dut_i (
		.clk_i      (clk_i),
		.reset_i    (reset_i),
		.pi1_op_o   (pi1_op_o),
		.pi1_addr_o (pi1_addr_o),
		.pi1_data_o (pi1_data_o),
		.pi1_data_i (pi1_data_i),
		.pi1_sel_o  (pi1_sel_o),
		.pi1_rdy_i  (pi1_rdy_i),
		.rstaddr_i  (rstaddr_i),
		.rstaddr2_i (rstaddr2_i),
		.id_i       (id_i),
		.halted_o   (halted_o)
	);

	bind multipu multipu_assertions #(.PUCOUNT(PUCOUNT)) assertions_i (
		.clk_i       (clk_i),
		.reset_i     (reset_i),
		.pi1_op_i    (pi1_op_o),
		.pi1_addr_i  (pi1_addr_o),
		.pi1_wdata_i (pi1_data_o),
		.pi1_rdy_i   (pi1_rdy_i),
		.halted_i    (halted_o)
	);

	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1);
	endtask

	// one instruction word at wr_ptr
	task automatic emit(input logic [OPCBITSZ-1:0] op, input int opnd);
		image[wr_ptr] = {op, OPNDBITSZ'(opnd)};
		wr_ptr = wr_ptr + 1;
	endtask

	// expected behavior of one unit, interpreted on its own copy of img
	function automatic void ref_run(input image_t img, input logic [ADDRBITSZ-1:0] start,
			input logic [ARCHBITSZ-1:0] id, output image_t res);
		logic [11:0]          pc;
		logic [ARCHBITSZ-1:0] acc;
		logic [ARCHBITSZ-1:0] insn;
		logic [11:0]          opnd;
		logic                 stop;
		int                   steps;
		res   = img;
		pc    = start[11:0];
		acc   = '0;
		stop  = 1'b0;
		steps = 0;
		// step cap stops a runaway program
		while (!stop && (steps < 4000)) begin
			insn  = res[pc];
			opnd  = insn[11:0];
			pc    = pc + 12'd1;
			steps = steps + 1;
			case (insn[15:12])
				OP_LDI:   acc = {4'h0, opnd};
				OP_LD:    acc = res[opnd];
				OP_ST:    res[opnd] = acc;
				OP_ADD:   acc = acc + res[opnd];
				OP_SUB:   acc = acc - res[opnd];
				OP_ID:    acc = id;
				OP_ADDID: acc = acc + id;
				OP_JMP:   pc = opnd;
				OP_JNZ: begin
					if (acc != '0) begin
						pc = opnd;
					end
				end
				OP_HALT:  stop = 1'b1;
				default:  acc = acc;
			endcase
		end
	endfunction

	task automatic build_image();
		for (int a = 0; a < MEMWORDS; a++) begin
			image[a] = 16'(a * 40503) ^ 16'h5a5a;
		end
		for (int i = 0; i < TABLE_LEN; i++) begin
			image[TABLE_BASE + i] = 16'($urandom);
		end
		image[ZERO_A] = '0;
		image[N_A]    = 16'(TABLE_LEN);
		image[ONE_A]  = 16'h0001;
		image[STOP_A] = {OP_ST, 12'h000};
		// unit 0 sums the table, the ADD at 0x015 steps its own operand
		wr_ptr = int'(START0);
		emit(OP_LD, ZERO_A);
		emit(OP_ST, SUM_A);
		emit(OP_LD, N_A);
		emit(OP_ST, CNT_A);
		emit(OP_LD, SUM_A);
		emit(OP_ADD, TABLE_BASE);
		emit(OP_ST, SUM_A);
		emit(OP_LD, 'h015);
		emit(OP_ADD, ONE_A);
		emit(OP_ST, 'h015);
		emit(OP_LD, CNT_A);
		emit(OP_SUB, ONE_A);
		emit(OP_ST, CNT_A);
		emit(OP_JNZ, 'h014);
		emit(OP_LD, SUM_A);
		emit(OP_ST, RES_A);
		emit(OP_HALT, 0);
		// unit 1 builds stores to base plus id and patches them in
		wr_ptr = int'(START1);
		emit(OP_LDI, OUT0_A);
		emit(OP_ADDID, 0);
		emit(OP_ADD, STOP_A);
		emit(OP_ST, 'h086);
		emit(OP_ID, 0);
		emit(OP_ADDID, 0);
		emit(4'h0, 0);
		emit(OP_LDI, OUT1_A);
		emit(OP_ADDID, 0);
		emit(OP_ADD, STOP_A);
		emit(OP_ST, 'h08d);
		emit(OP_LDI, 'habc);
		emit(OP_ADDID, 0);
		emit(4'h0, 0);
		emit(OP_HALT, 0);
	endtask

	// writes never overlap, so any changed word belongs to one unit
	task automatic build_expected(input logic [ARCHBITSZ-1:0] id);
		image_t res;
		expected = image;
		for (int u = 0; u < PUCOUNT; u++) begin
			ref_run(image, (u == 0) ? START0 : START1, id + 16'(u), res);
			for (int a = 0; a < MEMWORDS; a++) begin
				if (res[a] != image[a]) begin
					expected[a] = res[a];
				end
			end
		end
	endtask

	// memory model, one access at a time, rdy after 0 to 3 idle cycles
	always @(posedge clk_i) begin
		if (reset_i) begin
			mem = image;
			pi1_rdy_i <= 1'b0;
			armed      = 1'b0;
			first_seen = 1'b0;
		end else if (pi1_rdy_i) begin
			// rdy cycle just ended, the access is complete
			if (pi1_op_o == PI1_WR) begin
				mem[pi1_addr_o[11:0]] = pi1_data_o;
			end
			pi1_rdy_i <= 1'b0;
		end else if (pi1_op_o != PI1_NOP) begin
			assert (pi1_sel_o == '1)
			else report_error("a bus access used a partial byte select");
			if (!first_seen) begin
				assert ((pi1_op_o == PI1_RD) &&
					((pi1_addr_o == rstaddr_i) || (pi1_addr_o == rstaddr2_i)))
				else report_error("first bus access after reset is not a fetch at a start address");
				first_seen = 1'b1;
			end
			if (!armed) begin
				wait_cnt  = delay_tab[delay_idx];
				delay_idx = delay_idx + 12'd1;
				armed     = 1'b1;
			end
			if (wait_cnt == 2'd0) begin
				pi1_rdy_i  <= 1'b1;
				pi1_data_i <= mem[pi1_addr_o[11:0]];
				armed      = 1'b0;
			end else begin
				wait_cnt = wait_cnt - 2'd1;
			end
		end
	end

	// compares the memory model with the reference once all units halt
	initial begin
		forever begin
			wait (check_req != check_done);
			for (int a = 0; a < MEMWORDS; a++) begin
				assert (mem[a] === expected[a])
				else report_error($sformatf("Mismatch at %0t: address %03h expected %04h actual %04h",
					$time, a, expected[a], mem[a]));
			end
			check_done = check_done + 1;
		end
	end

	// bound protocol properties raise a flag when one of them fails
	always @(posedge clk_i) begin
		assert (!dut_i.assertions_i.any_fail)
		else report_error("a bus protocol assertion failed during the run");
	end

	always @(posedge clk_i) begin
		cycle_cnt <= cycle_cnt + 1;
		assert (cycle_cnt < TIMEOUT_CYCLES)
		else report_error($sformatf("timeout: the run did not finish in %0d cycles", TIMEOUT_CYCLES));
	end

	initial begin
		void'($urandom(32'h099e5a5b));
		for (int i = 0; i < MEMWORDS; i++) begin
			delay_tab[i] = 2'($urandom % 4);
		end
		for (int s = 0; s < NSCEN; s++) begin
			// units are halted or in reset here, mem is left alone
			build_image();
			build_expected(SCEN_ID[s]);
			@(posedge clk_i);
			id_i      <= SCEN_ID[s];
			reset_req <= (s > 0);
			@(posedge clk_i);
			reset_req <= 1'b0;
			@(posedge clk_i);
			while (reset_i) begin
				@(posedge clk_i);
			end
			assert (halted_o == '0)
			else report_error("halted_o is set right after reset");
			while (!(&halted_o)) begin
				@(posedge clk_i);
			end
			check_req = check_req + 1;
			wait (check_done == check_req);
			// bus must stay idle once everything halted
			repeat (50) begin
				@(posedge clk_i);
				assert (pi1_op_o == PI1_NOP)
				else report_error("a bus operation appeared after all units halted");
			end
		end
		// one more edge so a property failing in the last idle cycle is seen
		@(posedge clk_i);
		assert (!dut_i.assertions_i.any_fail)
		else report_error("a bus protocol assertion failed during the run");
		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: multipu.f
logic/pi1_pkg.sv
logic/pu_pkg.sv
logic/pi1_arbiter.sv
logic/pu.sv
logic/multipu.sv
verification/clock_gen.sv
verification/multipu_assertions.sv
verification/multipu_tb.sv

// File: Makefile
# Verilator simulation of the multipu cluster

VERILATOR ?= verilator
TOP       ?= multipu_tb
FILELIST  ?= multipu.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?=

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o $(TOP)_sim
	./$(BUILD_DIR)/$(TOP)_sim $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -q "Testbench passed" $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
